// ==== project.f ====
rtl/acq_pkg.sv
rtl/sample_packer.sv
rtl/capture_ram.sv
rtl/frame_player.sv
rtl/acq_top.sv
bench/acq_sva.sv
bench/acq_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the acquisition bank with Verilator and runs its testbench

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log

rm -rf "$build_dir"

verilator --binary --timing --assert \
   --top-module acq_tb \
   -Mdir "$build_dir" -o acq_sim \
   -f project.f > "$build_log" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
   cat "$build_log"
   echo "FAIL: Verilator build returned status $build_status"
   exit 1
fi

"./$build_dir/acq_sim" > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "Simulation FAILED" "$sim_log"; then
   echo "FAIL: testbench reported a failure, see $sim_log"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "FAIL: simulation returned status $sim_status"
   exit 1
fi
if ! grep -q "Simulation PASSED" "$sim_log"; then
   echo "FAIL: no pass report found in $sim_log"
   exit 1
fi

echo "PASS"
exit 0

// ==== bench/acq_tb.sv ====
`timescale 1ns/1ps

module acq_tb
   import acq_pkg::*;
;

   logic      clk;
   logic      reset;
   logic      mode;
   logic      sample_valid;
   sample_t   sample_in;
   logic      ready;
   play_out_t play;

   integer    seed = 32'h2bcc_1535;
   sample_t   captured[$]; // Every sample the DUT accepted in capture, oldest first

   acq_top DUT (
      .clk          (clk),
      .reset        (reset),
      .mode         (mode),
      .sample_valid (sample_valid),
      .sample_in    (sample_in),
      .ready        (ready),
      .play         (play)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_run();
      $display("Simulation FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: %s", what);
      stop_run();
   endtask

   task automatic compare_ready(input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch ready: got %h expected %h", got, exp);
         stop_run();
      end
   endtask

   task automatic compare_sample(input sample_t got, input sample_t exp);
      if (got !== exp) begin
         $display("mismatch play.sample: got %h expected %h", got, exp);
         stop_run();
      end
   endtask

   // Sample field is left to compare_sample
   task automatic compare_flags(input play_out_t got, input play_out_t exp);
      if (got.valid !== exp.valid) begin
         $display("mismatch play.valid: got %h expected %h", got.valid, exp.valid);
         stop_run();
      end
      if (got.frame_start !== exp.frame_start) begin
         $display("mismatch play.frame_start: got %h expected %h",
                  got.frame_start, exp.frame_start);
         stop_run();
      end
      if (got.frame_end !== exp.frame_end) begin
         $display("mismatch play.frame_end: got %h expected %h",
                  got.frame_end, exp.frame_end);
         stop_run();
      end
   endtask

   task automatic drive_random(output logic valid, output sample_t value);
      valid = (($random(seed) & 3) != 0); // Roughly one gap in four cycles
      value = sample_t'($random(seed));
      sample_valid <= valid;
      sample_in    <= value;
   endtask

   // Captures until target samples are accepted, checking ready every cycle
   task automatic capture_samples(input int target);
      int      count;
      int      cycles;
      int      limit;
      logic    done;
      logic    drv_valid;
      sample_t drv_sample;
      count  = 0;
      cycles = 0;
      limit  = target * 4 + 64;
      done   = 1'b0;
      @(posedge clk);
      mode <= MODE_CAPTURE;
      drive_random(drv_valid, drv_sample);
      while (!done) begin
         @(negedge clk);
         compare_ready(ready, count >= SAMPLES_PER_ACQ);
         if (cycles > 0) begin
            compare_flags(play, play_out_t'(0)); // Player must be idle in capture
         end
         if (cycles > limit) begin
            report_timeout("capture did not accept the requested number of samples");
         end
         @(posedge clk);
         cycles++;
         if (drv_valid) begin
            captured.push_back(drv_sample);
            count++;
         end
         if (count == target) begin
            sample_valid <= 1'b0;
            done = 1'b1;
         end else begin
            drive_random(drv_valid, drv_sample);
         end
      end
      @(negedge clk);
      compare_ready(ready, count >= SAMPLES_PER_ACQ);
   endtask

   // Plays back and checks several frames against the newest acquisition
   task automatic play_frames(input int frames);
      int        base;
      int        waited;
      int        limit;
      play_out_t exp;
      base   = captured.size() - SAMPLES_PER_ACQ;
      waited = 0;
      limit  = 32;
      @(posedge clk);
      mode <= MODE_PLAYBACK;
      @(negedge clk);
      while (play.frame_start !== 1'b1) begin
         compare_flags(play, play_out_t'(0));
         compare_ready(ready, 1'b0);
         waited++;
         if (waited > limit) begin
            report_timeout("playback never raised frame_start");
         end
         @(negedge clk);
      end
      for (int f = 0; f < frames; f++) begin
         for (int i = 0; i < SAMPLES_PER_ACQ; i++) begin
            exp             = '0;
            exp.valid       = 1'b1;
            exp.frame_start = (i == 0);
            exp.frame_end   = (i == SAMPLES_PER_ACQ - 1);
            exp.sample      = captured[base + i];
            compare_flags(play, exp);
            compare_sample(play.sample, exp.sample);
            @(negedge clk);
         end
         if (f < frames - 1) begin
            repeat (GAP_CYCLES) begin
               compare_flags(play, play_out_t'(0));
               @(negedge clk);
            end
         end
      end
   endtask

   initial begin
      int waited;
      reset        = 1'b1;
      mode         = MODE_CAPTURE;
      sample_valid = 1'b0;
      sample_in    = '0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      compare_ready(ready, 1'b0);
      compare_flags(play, play_out_t'(0));

      capture_samples(SAMPLES_PER_ACQ);
      play_frames(3);

      // 75 words, more than the buffer holds, so the write pointer wraps
      capture_samples(600);
      play_frames(3);

      // Fresh acquisition must replace the old one
      capture_samples(SAMPLES_PER_ACQ + 8);
      play_frames(3);

      // Leave playback in the middle of the next frame so valid has to drop
      waited = 0;
      while (play.valid !== 1'b1) begin
         waited++;
         if (waited > 32) begin
            report_timeout("playback did not resume after the frame gap");
         end
         @(negedge clk);
      end
      @(posedge clk);
      mode <= MODE_CAPTURE;
      repeat (2) @(negedge clk);
      compare_flags(play, play_out_t'(0));

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// ==== bench/acq_sva.sv ====
`timescale 1ns/1ps

module acq_sva
   import acq_pkg::*;
(
   input logic      clk,
   input logic      reset,
   input logic      mode,
   input logic      ready,
   input play_out_t play
);

   // A frame opens on a valid sample that follows an idle cycle
   a_start_after_idle: assert property (@(posedge clk) disable iff (reset)
      play.frame_start |-> (play.valid && !$past(play.valid)))
      else $error("frame_start without play.valid or without an idle cycle before it");

   // A frame closes on a valid sample and the next cycle is idle
   a_end_before_idle: assert property (@(posedge clk) disable iff (reset)
      $past(play.frame_end) |-> ($past(play.valid) && !play.valid))
      else $error("frame_end without play.valid or not followed by an idle cycle");

   a_valid_drops: assert property (@(posedge clk) disable iff (reset)
      (mode == MODE_CAPTURE) |=> !play.valid) // One cycle after capture is selected
      else $error("play.valid still high after mode returned to capture");

   // Only a switch to playback may take ready away
   a_ready_holds: assert property (@(posedge clk) disable iff (reset)
      $fell(ready) |-> (mode == MODE_PLAYBACK))
      else $error("ready fell while mode stayed in capture");

endmodule

bind acq_top acq_sva sva (
   .clk   (clk),
   .reset (reset),
   .mode  (mode),
   .ready (ready),
   .play  (play)
);

// ==== rtl/acq_top.sv ====
`timescale 1ns/1ps

module acq_top
   import acq_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      mode,
   input  logic      sample_valid,
   input  sample_t   sample_in,
   output logic      ready,
   output play_out_t play
);

   ram_wr_t wr;
   addr_t   acq_base;
   addr_t   rd_addr;
   word_t   rd_data;

   // Capture side fills the circular buffer
   sample_packer packer (
      .clk          (clk),
      .reset        (reset),
      .mode         (mode),
      .sample_valid (sample_valid),
      .sample_in    (sample_in),
      .wr           (wr),
      .acq_base     (acq_base),
      .ready        (ready)
   );

   capture_ram ram (
      .clk     (clk),
      .wr      (wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   // Replays the newest acquisition starting at acq_base
   frame_player player (
      .clk      (clk),
      .reset    (reset),
      .mode     (mode),
      .acq_base (acq_base),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .play     (play)
   );

endmodule

// ==== rtl/frame_player.sv ====
`timescale 1ns/1ps

module frame_player
   import acq_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      mode,
   input  addr_t     acq_base,
   output addr_t     rd_addr,
   input  word_t     rd_data,
   output play_out_t play
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_START,
      ST_GAP,
      ST_PLAY
   } state_t;

   typedef logic [$clog2(SAMPLES_PER_WORD)-1:0] idx_t;
   typedef logic [$clog2(WORDS_PER_ACQ)-1:0]    word_cnt_t;
   typedef logic [$clog2(GAP_CYCLES+1)-1:0]     gap_t;

   state_t    state_q;
   addr_t     rd_ptr_q;
   idx_t      idx_q;
   word_cnt_t word_cnt_q;
   gap_t      gap_q;
   word_t     shift_q;
   logic      playing;
   logic      last_idx;
   logic      last_word;
   logic      last_gap;
   logic      load_word;

   assign playing   = (state_q == ST_PLAY);
   assign last_idx  = (idx_q == idx_t'(SAMPLES_PER_WORD - 1));
   assign last_word = (word_cnt_q == word_cnt_t'(WORDS_PER_ACQ - 1));
   assign last_gap  = (gap_q == gap_t'(GAP_CYCLES - 1));

   // Next word has been in rd_data since the second sample of the current one
   assign load_word = (mode == MODE_PLAYBACK) &&
                      ((state_q == ST_GAP && last_gap) ||
                       (playing && last_idx && !last_word));

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q    <= ST_IDLE;
         rd_ptr_q   <= '0;
         idx_q      <= '0;
         word_cnt_q <= '0;
         gap_q      <= '0;
      end else if (mode == MODE_CAPTURE) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               state_q <= ST_START; // Lets a last pending capture write land
            end
            ST_START: begin
               rd_ptr_q <= acq_base;
               gap_q    <= '0;
               state_q  <= ST_GAP;
            end
            ST_GAP: begin
               if (last_gap) begin
                  rd_ptr_q   <= addr_inc(rd_ptr_q);
                  idx_q      <= '0;
                  word_cnt_q <= '0;
                  state_q    <= ST_PLAY;
               end else begin
                  gap_q <= gap_q + gap_t'(1);
               end
            end
            ST_PLAY: begin
               if (!last_idx) begin
                  idx_q <= idx_q + idx_t'(1);
               end else if (last_word) begin
                  idx_q    <= '0;
                  rd_ptr_q <= acq_base; // Rewind so word 0 is ready after the gap
                  gap_q    <= '0;
                  state_q  <= ST_GAP;
               end else begin
                  idx_q      <= '0;
                  rd_ptr_q   <= addr_inc(rd_ptr_q);
                  word_cnt_q <= word_cnt_q + word_cnt_t'(1);
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load_word) begin
         shift_q <= rd_data;
      end else if (playing) begin
         shift_q <= shift_q << SAMPLE_WIDTH;
      end
   end

   assign rd_addr = rd_ptr_q;

   assign play.valid       = playing;
   assign play.frame_start = playing && (idx_q == '0) && (word_cnt_q == '0);
   assign play.frame_end   = playing && last_idx && last_word;
   assign play.sample      = shift_q[WORD_WIDTH-1 -: SAMPLE_WIDTH];

endmodule

// ==== rtl/capture_ram.sv ====
`timescale 1ns/1ps

module capture_ram
   import acq_pkg::*;
(
   input  logic    clk,
   input  ram_wr_t wr,
   input  addr_t   rd_addr,
   output word_t   rd_data
);

   word_t mem [0:NUM_WORDS-1];

   // A read of the address being written returns the old word
   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== rtl/sample_packer.sv ====
`timescale 1ns/1ps

module sample_packer
   import acq_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    mode,
   input  logic    sample_valid,
   input  sample_t sample_in,
   output ram_wr_t wr,
   output addr_t   acq_base,
   output logic    ready
);

   typedef logic [$clog2(SAMPLES_PER_WORD)-1:0]  pos_t;
   typedef logic [$clog2(SAMPLES_PER_ACQ+1)-1:0] count_t;

   logic   mode_q;
   logic   enter_capture;
   logic   accept;
   pos_t   pos_q;
   pos_t   pos_base;
   count_t count_q;
   count_t count_base;
   logic   wr_en_q;
   addr_t  wr_addr_q;
   word_t  word_q;

   // First capture cycle after playback restarts the acquisition
   assign enter_capture = (mode == MODE_CAPTURE) && (mode_q == MODE_PLAYBACK);
   assign accept        = (mode == MODE_CAPTURE) && sample_valid;

   assign pos_base   = enter_capture ? '0 : pos_q;
   assign count_base = enter_capture ? '0 : count_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         mode_q    <= MODE_CAPTURE;
         pos_q     <= '0;
         count_q   <= '0;
         wr_en_q   <= 1'b0;
         wr_addr_q <= '0;
      end else begin
         mode_q  <= mode;
         wr_en_q <= accept && (pos_base == pos_t'(SAMPLES_PER_WORD - 1));

         if (accept) begin
            pos_q <= (pos_base == pos_t'(SAMPLES_PER_WORD - 1)) ? '0 : pos_base + pos_t'(1);
         end else begin
            pos_q <= pos_base;
         end

         // Saturates once a whole acquisition has been taken
         if (accept && (count_base != count_t'(SAMPLES_PER_ACQ))) begin
            count_q <= count_base + count_t'(1);
         end else begin
            count_q <= count_base;
         end

         if (wr_en_q) begin
            wr_addr_q <= addr_inc(wr_addr_q); // Write pointer survives mode changes
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         word_q <= {word_q[WORD_WIDTH-SAMPLE_WIDTH-1:0], sample_in};
      end
   end

   assign wr = '{en: wr_en_q, addr: wr_addr_q, data: word_q};

   // Modular subtraction gives the oldest of the last WORDS_PER_ACQ words
   assign acq_base = wr_addr_q - addr_t'(WORDS_PER_ACQ);

   assign ready = (mode == MODE_CAPTURE) && !enter_capture &&
                  (count_q == count_t'(SAMPLES_PER_ACQ));

endmodule

// ==== rtl/acq_pkg.sv ====
package acq_pkg;

   // Sample and word geometry
   localparam int SAMPLE_WIDTH     = 3;
   localparam int SAMPLES_PER_WORD = 8;
   localparam int WORD_WIDTH       = 24;

   // Circular buffer sizing
   localparam int NUM_WORDS        = 64;
   localparam int ADDR_WIDTH       = 6;
   localparam int WORDS_PER_ACQ    = 16;
   localparam int SAMPLES_PER_ACQ  = 128;

   localparam int GAP_CYCLES       = 4; // Idle cycles between playback frames

   localparam logic MODE_CAPTURE   = 1'b0;
   localparam logic MODE_PLAYBACK  = 1'b1;

   typedef logic [SAMPLE_WIDTH-1:0] sample_t;
   typedef logic [WORD_WIDTH-1:0]   word_t; // Oldest sample in the top bits
   typedef logic [ADDR_WIDTH-1:0]   addr_t;

   // Write request from the packer into the RAM
   typedef struct packed {
      logic  en;
      addr_t addr;
      word_t data;
   } ram_wr_t;

   typedef struct packed {
      logic    valid;
      logic    frame_start;
      logic    frame_end;
      sample_t sample;
   } play_out_t;

   // Next location in the circular buffer
   function automatic addr_t addr_inc(addr_t a);
      if (a == addr_t'(NUM_WORDS - 1)) begin
         return '0;
      end
      return a + addr_t'(1);
   endfunction

endpackage
